//--- common/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// address and instruction widths.
`define SIZE_PC          32
`define SIZE_INSTRUCTION 32

// slots per fetch bundle and the byte step between them.
`define FETCH_WIDTH      4
`define INST_BYTES       4

// cti queue entries and tag width.
`define CTIQ_DEPTH       16
`define CTIQ_LOG         4

// primary opcode field.
`define OPCODE_MSB       31
`define OPCODE_LSB       26

`endif

//--- common/FetchPkg.sv
`include "fetch_defines.svh"

package FetchPkg;

  // primary opcodes that matter to fetch.
  typedef enum logic [5:0] {
    OP_J   = 6'h02,
    OP_JAL = 6'h03,
    OP_BEQ = 6'h04,
    OP_JR  = 6'h08
  } OpcodeE;

  typedef struct packed {
    logic [`SIZE_PC-1:0]                              pc;
    logic [`FETCH_WIDTH-1:0][`SIZE_INSTRUCTION-1:0]   instr;  // slot 0 in low word.
  } FetchBundleS;

  typedef struct packed {
    logic                btbHit;
    logic                prediction;
    logic [`SIZE_PC-1:0] btbTarget;
  } SlotHintS;

  typedef struct packed {
    logic [`SIZE_INSTRUCTION-1:0] instruction;
    logic [`SIZE_PC-1:0]          pc;
    logic [`SIZE_PC-1:0]          target;
    logic [`CTIQ_LOG-1:0]         ctiTag;
    logic                         prediction;
  } InstPacketS;

endpackage

//--- common/CtiPkg.sv
`include "fetch_defines.svh"

package CtiPkg;

  typedef enum logic [1:0] {
    CTI_RETURN = 2'd0,
    CTI_CALL   = 2'd1,
    CTI_JUMP   = 2'd2,
    CTI_COND   = 2'd3
  } CtiTypeE;

  typedef logic [`CTIQ_LOG-1:0] CtiTagT;

  typedef struct packed {
    CtiTagT              tag;
    logic                taken;
    logic [`SIZE_PC-1:0] target;
  } ResolveS;

  typedef struct packed {
    logic                recover;
    logic                isReturn;
    logic                isCall;
    logic [`SIZE_PC-1:0] target;
    logic [`SIZE_PC-1:0] callPc;
  } RedirectS;

  typedef struct packed {
    logic [`SIZE_PC-1:0] pc;
    logic [`SIZE_PC-1:0] target;
    CtiTypeE             ctiType;
    logic                taken;
    logic                en;      // one cycle per commit.
  } CtiUpdateS;

endpackage

//--- logic/PreDecode.sv
`timescale 1ns/10ps
`include "fetch_defines.svh"

module PreDecode
  import FetchPkg::*;
  import CtiPkg::*;
(
  input  logic [`SIZE_INSTRUCTION-1:0] instruction_i,
  input  logic [`SIZE_PC-1:0]          pc_i,
  input  logic [`SIZE_PC-1:0]          btbTarget_i,
  input  logic [`SIZE_PC-1:0]          rasAddr_i,
  output logic                         isCti_o,
  output CtiTypeE                      ctiType_o,
  output logic [`SIZE_PC-1:0]          target_o
);

  OpcodeE              opcode;
  logic [`SIZE_PC-1:0] seqPc;
  logic [`SIZE_PC-1:0] brOffset;
  logic [`SIZE_PC-1:0] jmpTarget;

  assign opcode = OpcodeE'(instruction_i[`OPCODE_MSB:`OPCODE_LSB]);
  assign seqPc  = pc_i + `SIZE_PC'(`INST_BYTES);

  // word offset, sign extended.
  assign brOffset  = {{(`SIZE_PC-18){instruction_i[15]}}, instruction_i[15:0], 2'b00};
  assign jmpTarget = {pc_i[`SIZE_PC-1 -: 4], instruction_i[25:0], 2'b00};  // region jump.

  always_comb begin
    isCti_o   = 1'b1;
    ctiType_o = CTI_COND;
    target_o  = btbTarget_i;
    case (opcode)
      OP_BEQ: begin
        target_o = seqPc + brOffset;
      end
      OP_J: begin
        ctiType_o = CTI_JUMP;
        target_o  = jmpTarget;
      end
      OP_JAL: begin
        ctiType_o = CTI_CALL;
        target_o  = jmpTarget;
      end
      OP_JR: begin
        ctiType_o = CTI_RETURN;
        target_o  = rasAddr_i;  // top of stack.
      end
      default: begin
        isCti_o = 1'b0;  // btb target passes through.
      end
    endcase
  end

endmodule

//--- fetch/BtbValidate.sv
`timescale 1ns/10ps
`include "fetch_defines.svh"

module BtbValidate
  import FetchPkg::*;
  import CtiPkg::*;
(
  input  logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0] pc_i,
  input  logic [`FETCH_WIDTH-1:0]               isCti_i,
  input  CtiTypeE [`FETCH_WIDTH-1:0]            ctiType_i,
  input  logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0] target_i,
  input  SlotHintS [`FETCH_WIDTH-1:0]           hint_i,
  input  logic                                  stall_i,
  input  logic                                  queueFull_i,
  output logic [`FETCH_WIDTH-1:0]               validMask_o,
  output logic [`FETCH_WIDTH-1:0]               pushVec_o,
  output RedirectS                              redirect_o
);

  localparam int SEL_W = $clog2(`FETCH_WIDTH);

  logic [`FETCH_WIDTH-1:0] redirSlot;
  logic [SEL_W-1:0]        sel;
  logic                    found;
  logic                    rawRecover;

  // not-taken conditionals fall through, everything else redirects.
  always_comb begin
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      redirSlot[i] = isCti_i[i] & (hint_i[i].prediction | (ctiType_i[i] != CTI_COND));
    end
  end

  // lowest redirecting slot wins.
  always_comb begin
    found = 1'b0;
    sel   = '0;
    for (int i = `FETCH_WIDTH - 1; i >= 0; i--) begin
      if (redirSlot[i]) begin
        found = 1'b1;
        sel   = SEL_W'(i);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      validMask_o[i] = ~found | (SEL_W'(i) <= sel);
      pushVec_o[i]   = isCti_i[i] & (~found | (SEL_W'(i) <= sel));
    end
  end

  assign rawRecover = found & ~hint_i[sel].btbHit;  // btb did not see it.

  always_comb begin
    redirect_o.recover  = rawRecover & ~stall_i & ~queueFull_i;
    redirect_o.isReturn = redirect_o.recover & (ctiType_i[sel] == CTI_RETURN);
    redirect_o.isCall   = redirect_o.recover & (ctiType_i[sel] == CTI_CALL);
    redirect_o.target   = target_i[sel];
    redirect_o.callPc   = pc_i[sel];
  end

endmodule

//--- ctiQueue/CtiQueue.sv
`timescale 1ns/10ps
`include "fetch_defines.svh"

module CtiQueue
  import CtiPkg::*;
(
  input  logic                                  clk,
  input  logic                                  reset_i,
  input  logic                                  fs1Ready_i,
  input  logic                                  stall_i,
  input  logic                                  flush_i,
  input  logic [`FETCH_WIDTH-1:0]               pushVec_i,
  input  logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0] pc_i,
  input  CtiTypeE [`FETCH_WIDTH-1:0]            ctiType_i,
  input  logic                                  resolveEn_i,
  input  ResolveS                               resolve_i,
  input  logic                                  commit_i,
  output CtiTagT [`FETCH_WIDTH-1:0]             tag_o,
  output CtiUpdateS                             update_o,
  output logic                                  full_o,
  output logic                                  fs2Ready_o
);

  logic [`SIZE_PC-1:0] pcQ     [`CTIQ_DEPTH];
  CtiTypeE             typeQ   [`CTIQ_DEPTH];
  logic [`SIZE_PC-1:0] targetQ [`CTIQ_DEPTH];
  logic                takenQ  [`CTIQ_DEPTH];

  CtiTagT              head;
  CtiTagT              tail;
  logic [`CTIQ_LOG:0]  count;
  logic [`CTIQ_LOG:0]  pushCnt;
  logic [`CTIQ_LOG:0]  pushAmt;
  logic                pushEn;

  // tags follow the tail in slot order.
  always_comb begin
    pushCnt = '0;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      tag_o[i] = tail + pushCnt[`CTIQ_LOG-1:0];
      if (pushVec_i[i]) begin
        pushCnt = pushCnt + 1'b1;
      end
    end
  end

  assign full_o     = count > (`CTIQ_DEPTH - `FETCH_WIDTH);  // room for a whole bundle.
  assign fs2Ready_o = fs1Ready_i & ~full_o;
  assign pushEn     = fs1Ready_i & ~stall_i & ~full_o;
  assign pushAmt    = pushEn ? pushCnt : '0;

  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      tail  <= tail + pushAmt[`CTIQ_LOG-1:0];
      head  <= head + {{(`CTIQ_LOG-1){1'b0}}, commit_i};
      count <= count + pushAmt - {{`CTIQ_LOG{1'b0}}, commit_i};
    end
  end

  always_ff @(posedge clk) begin
    if (pushEn) begin
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
        if (pushVec_i[i]) begin
          pcQ[tag_o[i]]   <= pc_i[i];
          typeQ[tag_o[i]] <= ctiType_i[i];
        end
      end
    end
    if (resolveEn_i) begin
      targetQ[resolve_i.tag] <= resolve_i.target;  // outcome from execute.
      takenQ[resolve_i.tag]  <= resolve_i.taken;
    end
  end

  // update record leaves one cycle after commit.
  always_ff @(posedge clk) begin
    update_o.pc      <= pcQ[head];
    update_o.target  <= targetQ[head];
    update_o.ctiType <= typeQ[head];
    update_o.taken   <= takenQ[head];
    if (reset_i || flush_i) begin
      update_o.en <= 1'b0;
    end else begin
      update_o.en <= commit_i;
    end
  end

  countBound: assert property (@(posedge clk) disable iff (reset_i)
    count <= `CTIQ_DEPTH)
    else $error("cti queue overflow");

  commitNotEmpty: assert property (@(posedge clk) disable iff (reset_i || flush_i)
    commit_i |-> count != '0)
    else $error("commit with empty cti queue");

endmodule

//--- fetch/FetchStage2.sv
`timescale 1ns/10ps
`include "fetch_defines.svh"

module FetchStage2
  import FetchPkg::*;
  import CtiPkg::*;
(
  input  logic                         clk,
  input  logic                         reset_i,
  input  FetchBundleS                  bundle_i,
  input  SlotHintS [`FETCH_WIDTH-1:0]  hint_i,
  input  logic [`SIZE_PC-1:0]          rasAddr_i,
  input  logic                         fs1Ready_i,
  input  logic                         stall_i,
  input  logic                         flush_i,
  input  logic                         resolveEn_i,
  input  ResolveS                      resolve_i,
  input  logic                         commit_i,
  output InstPacketS [`FETCH_WIDTH-1:0] packet_o,
  output logic [`FETCH_WIDTH-1:0]      validMask_o,
  output RedirectS                     redirect_o,
  output CtiUpdateS                    update_o,
  output logic                         fs2Ready_o,
  output logic                         queueFull_o
);

  logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0] slotPc;
  logic [`FETCH_WIDTH-1:0][`SIZE_PC-1:0] decTarget;
  logic [`FETCH_WIDTH-1:0]               isCti;
  CtiTypeE [`FETCH_WIDTH-1:0]            ctiType;
  logic [`FETCH_WIDTH-1:0]               pushVec;
  CtiTagT [`FETCH_WIDTH-1:0]             tags;

  always_comb begin
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      slotPc[i]                = bundle_i.pc + `SIZE_PC'(i * `INST_BYTES);
      packet_o[i].instruction  = bundle_i.instr[i];
      packet_o[i].pc           = slotPc[i];
      packet_o[i].target       = decTarget[i];
      packet_o[i].ctiTag       = tags[i];
      packet_o[i].prediction   = hint_i[i].prediction;
    end
  end

  for (genvar g = 0; g < `FETCH_WIDTH; g++) begin : genPreDecode
    PreDecode preDecode (
      .instruction_i(bundle_i.instr[g]),
      .pc_i         (slotPc[g]),
      .btbTarget_i  (hint_i[g].btbTarget),
      .rasAddr_i    (rasAddr_i),
      .isCti_o      (isCti[g]),
      .ctiType_o    (ctiType[g]),
      .target_o     (decTarget[g])
    );
  end

  BtbValidate btbValidate (
    .pc_i       (slotPc),
    .isCti_i    (isCti),
    .ctiType_i  (ctiType),
    .target_i   (decTarget),
    .hint_i     (hint_i),
    .stall_i    (stall_i),
    .queueFull_i(queueFull_o),
    .validMask_o(validMask_o),
    .pushVec_o  (pushVec),
    .redirect_o (redirect_o)
  );

  CtiQueue ctiQueue (
    .clk        (clk),
    .reset_i    (reset_i),
    .fs1Ready_i (fs1Ready_i),
    .stall_i    (stall_i),
    .flush_i    (flush_i),
    .pushVec_i  (pushVec),
    .pc_i       (slotPc),
    .ctiType_i  (ctiType),
    .resolveEn_i(resolveEn_i),
    .resolve_i  (resolve_i),
    .commit_i   (commit_i),
    .tag_o      (tags),
    .update_o   (update_o),
    .full_o     (queueFull_o),
    .fs2Ready_o (fs2Ready_o)
  );

endmodule

//--- sim/FetchStage2Tb.sv
`timescale 1ns/10ps
`include "fetch_defines.svh"

module FetchStage2Tb
  import FetchPkg::*;
  import CtiPkg::*;
();

  localparam int          RESET_CYCLES = 3;
  localparam int          MAX_GAP      = 3;
  localparam logic [31:0] SEED         = 32'he7b4_81fe;

  logic                          clk;
  logic                          reset;
  FetchBundleS                   bundle;
  SlotHintS [`FETCH_WIDTH-1:0]   hint;
  logic [`SIZE_PC-1:0]           rasAddr;
  logic                          fs1Ready;
  logic                          stall;
  logic                          flush;
  logic                          resolveEn;
  ResolveS                       resolve;
  logic                          commit;
  InstPacketS [`FETCH_WIDTH-1:0] packet;
  logic [`FETCH_WIDTH-1:0]       validMask;
  RedirectS                      redirect;
  CtiUpdateS                     update;
  logic                          fs2Ready;
  logic                          queueFull;

  string       lines[$];
  int          errCnt     = 0;
  int          checkCnt   = 0;
  int          cycleCnt   = 0;
  int          cycleLimit = 1000;
  int          fd;

  FetchStage2 UUT (
    .clk        (clk),
    .reset_i    (reset),
    .bundle_i   (bundle),
    .hint_i     (hint),
    .rasAddr_i  (rasAddr),
    .fs1Ready_i (fs1Ready),
    .stall_i    (stall),
    .flush_i    (flush),
    .resolveEn_i(resolveEn),
    .resolve_i  (resolve),
    .commit_i   (commit),
    .packet_o   (packet),
    .validMask_o(validMask),
    .redirect_o (redirect),
    .update_o   (update),
    .fs2Ready_o (fs2Ready),
    .queueFull_o(queueFull)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycleCnt++;
    if (cycleCnt > cycleLimit) begin
      $display("timeout: golden run still going after %0d cycles", cycleCnt);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
    checkCnt++;
    if (got !== exp) begin
      errCnt++;
      $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic clearStrobes();
    fs1Ready  = 1'b0;
    stall     = 1'b0;
    flush     = 1'b0;
    resolveEn = 1'b0;
    commit    = 1'b0;
  endtask

  task automatic sendBundle(input string args);
    logic [31:0] pc, i0, i1, i2, i3, ras, target, callPc;
    logic [3:0]  hit, pred, mask, flags;
    logic [15:0] tags;
    logic        stallBit, full;
    logic [`FETCH_WIDTH-1:0][31:0] instrs;
    int          n;
    int          k;
    n = $sscanf(args, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", pc, i0, i1, i2, i3,
                hit, pred, ras, stallBit, mask, tags, flags, target, callPc, full);
    if (n != 15) begin
      errCnt++;
      $display("bundle line in golden file has %0d fields instead of 15", n);
    end else begin
      @(negedge clk);
      instrs       = {i3, i2, i1, i0};
      bundle.pc    = pc;
      bundle.instr = instrs;
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
        hint[i].btbHit     = hit[i];
        hint[i].prediction = pred[i];
        hint[i].btbTarget  = '0;
      end
      rasAddr  = ras;
      stall    = stallBit;
      fs1Ready = 1'b1;
      #2;
      k = 0;
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
        checkValue($sformatf("slot %0d pc", i), packet[i].pc, pc + 32'(4 * i));  // block pc + 4i.
        checkValue($sformatf("slot %0d tag", i), 32'(packet[i].ctiTag), 32'(tags[4*i +: 4]));
        checkValue($sformatf("slot %0d instruction", i), packet[i].instruction, instrs[i]);
        checkValue($sformatf("slot %0d prediction", i), 32'(packet[i].prediction),
                   32'(pred[i]));
        if (mask[i]) k = i;
      end
      checkValue("valid mask", 32'(validMask), 32'(mask));
      checkValue("recover", 32'(redirect.recover), 32'(flags[2]));
      checkValue("isReturn", 32'(redirect.isReturn), 32'(flags[1]));
      checkValue("isCall", 32'(redirect.isCall), 32'(flags[0]));
      checkValue("queue full", 32'(queueFull), 32'(full));
      checkValue("fs2 ready", 32'(fs2Ready), 32'(!full));
      if (flags[3]) begin
        checkValue("redirect target", redirect.target, target);
        checkValue("redirect callPc", redirect.callPc, callPc);
        checkValue("redirect slot packet target", packet[k].target, target);
      end
      @(negedge clk);
      clearStrobes();
    end
  endtask

  task automatic resolveTag(input string args);
    logic [3:0]  tag;
    logic        taken;
    logic [31:0] target;
    int          n;
    n = $sscanf(args, "%h %h %h", tag, taken, target);
    if (n != 3) begin
      errCnt++;
      $display("resolve line in golden file has %0d fields instead of 3", n);
    end else begin
      @(negedge clk);
      resolve.tag    = tag;
      resolve.taken  = taken;
      resolve.target = target;
      resolveEn      = 1'b1;
      @(negedge clk);
      clearStrobes();
    end
  endtask

  task automatic commitHead(input string args);
    logic [31:0] pc, target;
    logic [1:0]  ctiType;
    logic        taken;
    int          n;
    n = $sscanf(args, "%h %h %h %h", pc, target, ctiType, taken);
    if (n != 4) begin
      errCnt++;
      $display("commit line in golden file has %0d fields instead of 4", n);
    end else begin
      @(negedge clk);
      commit = 1'b1;
      @(negedge clk);
      clearStrobes();
      checkValue("update en", 32'(update.en), 32'd1);  // registered one cycle after commit.
      checkValue("update pc", update.pc, pc);
      checkValue("update target", update.target, target);
      checkValue("update type", 32'(update.ctiType), 32'(ctiType));
      checkValue("update taken", 32'(update.taken), 32'(taken));
      @(negedge clk);
      checkValue("update en one cycle later", 32'(update.en), 32'd0);
    end
  endtask

  task automatic flushQueue();
    @(negedge clk);
    flush  = 1'b1;
    commit = 1'b1;  // flush has to win over a commit.
    @(negedge clk);
    clearStrobes();
    checkValue("update en after flush", 32'(update.en), 32'd0);
  endtask

  task automatic runVector(input string line);
    string args;
    args = line.substr(2, line.len() - 1);
    case (line.getc(0))
      "B": sendBundle(args);
      "R": resolveTag(args);
      "C": commitHead(args);
      "F": flushQueue();
      default: begin
        errCnt++;
        $display("unknown command in golden line: %s", line);
      end
    endcase
  endtask

  initial begin
    string line;
    int    gap;
    reset   = 1'b1;
    bundle  = '0;
    hint    = '0;
    rasAddr = '0;
    resolve = '0;
    clearStrobes();
    commit  = 1'b1;  // reset has to win over a commit.
    void'($urandom(SEED));  // idle gaps only.
    fd = $fopen("sim/fetch_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open golden file sim/fetch_golden.txt");
      $display("** FAIL **");
      $finish;
    end else begin
      while ($fgets(line, fd)) begin
        if (line.len() > 1 && line.getc(0) != "#") lines.push_back(line);
      end
      $fclose(fd);
      cycleLimit = RESET_CYCLES + 10 + lines.size() * (4 + MAX_GAP);
      repeat (RESET_CYCLES) @(negedge clk);
      reset    = 1'b0;
      commit   = 1'b0;
      fs1Ready = 1'b1;
      #2;
      checkValue("update en after reset", 32'(update.en), 32'd0);
      checkValue("fs2 ready after reset", 32'(fs2Ready), 32'd1);  // empty queue.
      clearStrobes();
      foreach (lines[i]) begin
        runVector(lines[i]);
        gap = $urandom_range(0, MAX_GAP);
        repeat (gap) @(negedge clk);
      end
      @(negedge clk);
      $display("vectors %0d, checks %0d, errors %0d", lines.size(), checkCnt, errCnt);
      if (errCnt == 0) begin
        $display("** PASS **");
      end else begin
        $display("** FAIL **");
      end
      $finish;
    end
  end

endmodule

//--- sim/fetch_golden.txt
# B pc i0 i1 i2 i3 hit pred ras stall | mask tags(s3..s0) flags(found,rec,ret,call) target callPc full
# R tag taken target | C pc target type taken (expected update) | F flush
B 00001000 00000000 10000003 00000000 1000fffe 0 0 00000000 0 f 1100 0 00000000 00000000 0
B 00002000 00000000 10000010 08000400 00000000 2 2 00000000 0 3 3322 8 00002048 00002004 0
B 00003000 00000000 00000000 08000d00 10000001 0 0 00000000 0 7 4333 c 00003400 00003008 0
B 00004000 20000000 00000000 00000000 00000000 0 0 0000abc0 0 1 5554 e 0000abc0 00004000 0
B 10005000 00000000 0c000800 00000000 00000000 0 0 00000000 0 3 6655 d 10002000 10005004 0
B 00006000 08000100 00000000 00000000 00000000 0 0 00000000 1 1 7776 8 00000400 00006000 0
R 0 0 00001008
R 1 1 00001008
C 00001004 00001008 3 0
C 0000100c 00001008 3 1
B 00007000 10000000 10000000 10000000 10000000 0 0 00000000 0 f 9876 0 00000000 00000000 0
B 00008000 10000000 10000000 10000000 10000000 0 0 00000000 0 f dcba 0 00000000 00000000 0
B 00009000 10000000 08000000 00000000 00000000 0 0 00000000 0 3 00fe c 00000000 00009004 0
B 0000a000 08000200 00000000 00000000 00000000 0 0 00000000 0 1 1110 8 00000800 0000a000 1
R 2 1 00002048
C 00002004 00002048 3 1
R 3 1 00003400
C 00003008 00003400 2 1
B 0000a000 08000200 00000000 00000000 00000000 0 0 00000000 0 1 1110 c 00000800 0000a000 0
F
B 0000b000 10000000 00000000 00000000 00000000 0 0 00000000 0 f 1110 0 00000000 00000000 0
R 0 0 0000b004
C 0000b000 0000b004 3 0

//--- vlog.f
+incdir+common
common/FetchPkg.sv
common/CtiPkg.sv
logic/PreDecode.sv
fetch/BtbValidate.sv
ctiQueue/CtiQueue.sv
fetch/FetchStage2.sv
sim/FetchStage2Tb.sv

//--- Bender.yml
package:
  name: fetch_stage2

sources:
  - include_dirs:
      - common
    files:
      - common/FetchPkg.sv
      - common/CtiPkg.sv
      - logic/PreDecode.sv
      - fetch/BtbValidate.sv
      - ctiQueue/CtiQueue.sv
      - fetch/FetchStage2.sv
      - target: simulation
        files:
          - sim/FetchStage2Tb.sv
